//--- common/phy_cfg_pkg.sv
////////////////////////////////////////////////////////////
// DDR3 PHY configuration
// Memory and AFI widths, datapath pipeline depths and the
// data types carried between controller and memory side
////////////////////////////////////////////////////////////

`default_nettype none

package phy_cfg_pkg;

    // Memory side
    localparam int MEM_ADDR_WIDTH = 14;
    localparam int MEM_BANK_WIDTH = 3;
    localparam int MEM_DQ_WIDTH   = 16;
    localparam int MEM_DQS_GROUPS = 2;

    // Half rate, so each AFI cycle carries four DQ beats
    localparam int AFI_RATE_RATIO = 2;
    localparam int AFI_DATA_WIDTH = 2 * AFI_RATE_RATIO * MEM_DQ_WIDTH;
    localparam int AFI_DM_WIDTH   = AFI_DATA_WIDTH / 8;
    localparam int AFI_DQS_WIDTH  = MEM_DQS_GROUPS * AFI_RATE_RATIO;

    localparam int AC_FLOP_STAGES    = 2;
    localparam int WRITE_FLOP_STAGES = 3;
    localparam int READ_FIFO_DEPTH   = 8;

    typedef logic [AFI_DATA_WIDTH-1:0] afi_data_t;
    typedef logic [AFI_DM_WIDTH-1:0]   afi_mask_t;
    typedef logic [AFI_DQS_WIDTH-1:0]  afi_dqs_t;
    typedef logic [MEM_ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [MEM_BANK_WIDTH-1:0] mem_bank_t;

endpackage

`default_nettype wire

//--- common/phy_ctrl_pkg.sv
////////////////////////////////////////////////////////////
// DDR3 PHY control definitions
// Reset sequencer states, settle time and the widths of
// the settle timer and read latency setting
////////////////////////////////////////////////////////////

`default_nettype none

package phy_ctrl_pkg;

    typedef enum logic [1:0] {
        RST_WAIT_LOCK = 2'd0,
        RST_SETTLE    = 2'd1,
        RST_RUN       = 2'd2
    } reset_state_t;

    // Cycles of stable lock before the datapath leaves reset
    localparam int SETTLE_CYCLES = 16;
    typedef logic [$clog2(SETTLE_CYCLES+1)-1:0] settle_cnt_t;

    // One reset each for command, write and read blocks
    localparam int NUM_PHY_RESET = 3;

    localparam int MAX_READ_LATENCY = 15;
    typedef logic [$clog2(MAX_READ_LATENCY+1)-1:0] rd_lat_t;

endpackage

`default_nettype wire

//--- design/addr_cmd_path.sv
////////////////////////////////////////////////////////////
// Address and command path
// Registers AFI command fields toward the memory outputs,
// driving a deselect with CKE low while held in reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module addr_cmd_path
    import phy_cfg_pkg::*;
(
    input  wire            pll_afi_clk,
    input  wire            rst_n,
    input  wire            blk_rst_n,
    input  wire mem_addr_t afi_addr,
    input  wire mem_bank_t afi_ba,
    input  wire            afi_cs_n,
    input  wire            afi_ras_n,
    input  wire            afi_cas_n,
    input  wire            afi_we_n,
    input  wire            afi_cke,
    input  wire            afi_odt,
    output mem_addr_t      mem_a,
    output mem_bank_t      mem_ba,
    output logic           mem_cs_n,
    output logic           mem_ras_n,
    output logic           mem_cas_n,
    output logic           mem_we_n,
    output logic           mem_cke,
    output logic           mem_odt
);

    typedef struct packed {
        mem_addr_t a;
        mem_bank_t ba;
        logic      cs_n;
        logic      ras_n;
        logic      cas_n;
        logic      we_n;
        logic      cke;
        logic      odt;
    } ac_word_t;

    ac_word_t afi_word;
    ac_word_t stage [AC_FLOP_STAGES];

    function automatic ac_word_t nop_word();
        ac_word_t w;
        w       = '0;
        w.cs_n  = 1'b1;
        w.ras_n = 1'b1;
        w.cas_n = 1'b1;
        w.we_n  = 1'b1;
        return w;
    endfunction

    assign afi_word = '{a: afi_addr, ba: afi_ba, cs_n: afi_cs_n, ras_n: afi_ras_n,
                        cas_n: afi_cas_n, we_n: afi_we_n, cke: afi_cke, odt: afi_odt};

    always_ff @(posedge pll_afi_clk or negedge rst_n)
    begin
        if (!rst_n || !blk_rst_n)
        begin
            for (int i = 0; i < AC_FLOP_STAGES; i++)
            begin
                stage[i] <= nop_word();
            end
        end
        else
        begin
            stage[0] <= afi_word;
            for (int i = 1; i < AC_FLOP_STAGES; i++)
            begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign mem_a     = stage[AC_FLOP_STAGES-1].a;
    assign mem_ba    = stage[AC_FLOP_STAGES-1].ba;
    assign mem_cs_n  = stage[AC_FLOP_STAGES-1].cs_n;
    assign mem_ras_n = stage[AC_FLOP_STAGES-1].ras_n;
    assign mem_cas_n = stage[AC_FLOP_STAGES-1].cas_n;
    assign mem_we_n  = stage[AC_FLOP_STAGES-1].we_n;
    assign mem_cke   = stage[AC_FLOP_STAGES-1].cke;
    assign mem_odt   = stage[AC_FLOP_STAGES-1].odt;

endmodule

`default_nettype wire

//--- design/ddr_phy_core.sv
////////////////////////////////////////////////////////////
// DDR3 half-rate PHY core, AFI side
// Ties together reset sequencing, the command and write
// pipelines and the read FIFO with its valid predictor
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module ddr_phy_core
    import phy_cfg_pkg::*;
    import phy_ctrl_pkg::*;
(
    input  wire                       pll_afi_clk,
    input  wire                       rst_n,
    input  wire                       pll_locked,
    input  wire                       soft_reset_n,
    output logic                      ctl_reset_n,
    // AFI command
    input  wire mem_addr_t            afi_addr,
    input  wire mem_bank_t            afi_ba,
    input  wire                       afi_cs_n,
    input  wire                       afi_ras_n,
    input  wire                       afi_cas_n,
    input  wire                       afi_we_n,
    input  wire                       afi_cke,
    input  wire                       afi_odt,
    // AFI write
    input  wire afi_data_t            afi_wdata,
    input  wire afi_mask_t            afi_dm,
    input  wire afi_dqs_t             afi_wdata_valid,
    input  wire afi_dqs_t             afi_dqs_burst,
    // AFI read
    input  wire [AFI_RATE_RATIO-1:0]  afi_rdata_en,
    input  wire rd_lat_t              phy_read_latency,
    output afi_data_t                 afi_rdata,
    output logic [AFI_RATE_RATIO-1:0] afi_rdata_valid,
    output logic                      read_underflow,
    output logic                      read_overflow,
    // Memory side
    output mem_addr_t                 mem_a,
    output mem_bank_t                 mem_ba,
    output logic                      mem_cs_n,
    output logic                      mem_ras_n,
    output logic                      mem_cas_n,
    output logic                      mem_we_n,
    output logic                      mem_cke,
    output logic                      mem_odt,
    output afi_data_t                 mem_wdata,
    output afi_mask_t                 mem_dm,
    output afi_dqs_t                  mem_wdata_en,
    output afi_dqs_t                  mem_dqs_en,
    input  wire afi_data_t            mem_rdata,
    input  wire                       mem_rdata_strobe
);

    logic                     settle_start;
    logic                     settle_done;
    logic [NUM_PHY_RESET-1:0] blk_rst_n;
    logic                     rd_pop;

    phy_reset_fsm u_reset_fsm (
        .pll_afi_clk  (pll_afi_clk),
        .rst_n        (rst_n),
        .pll_locked   (pll_locked),
        .soft_reset_n (soft_reset_n),
        .settle_done  (settle_done),
        .settle_start (settle_start),
        .ctl_reset_n  (ctl_reset_n),
        .blk_rst_n    (blk_rst_n)
    );

    reset_settle_timer u_settle_timer (
        .pll_afi_clk  (pll_afi_clk),
        .rst_n        (rst_n),
        .settle_start (settle_start),
        .settle_done  (settle_done)
    );

    addr_cmd_path u_addr_cmd (
        .pll_afi_clk (pll_afi_clk),
        .rst_n       (rst_n),
        .blk_rst_n   (blk_rst_n[0]),
        .afi_addr    (afi_addr),
        .afi_ba      (afi_ba),
        .afi_cs_n    (afi_cs_n),
        .afi_ras_n   (afi_ras_n),
        .afi_cas_n   (afi_cas_n),
        .afi_we_n    (afi_we_n),
        .afi_cke     (afi_cke),
        .afi_odt     (afi_odt),
        .mem_a       (mem_a),
        .mem_ba      (mem_ba),
        .mem_cs_n    (mem_cs_n),
        .mem_ras_n   (mem_ras_n),
        .mem_cas_n   (mem_cas_n),
        .mem_we_n    (mem_we_n),
        .mem_cke     (mem_cke),
        .mem_odt     (mem_odt)
    );

    write_path u_write (
        .pll_afi_clk     (pll_afi_clk),
        .rst_n           (rst_n),
        .blk_rst_n       (blk_rst_n[1]),
        .afi_wdata       (afi_wdata),
        .afi_dm          (afi_dm),
        .afi_wdata_valid (afi_wdata_valid),
        .afi_dqs_burst   (afi_dqs_burst),
        .mem_wdata       (mem_wdata),
        .mem_dm          (mem_dm),
        .mem_wdata_en    (mem_wdata_en),
        .mem_dqs_en      (mem_dqs_en)
    );

    // Read FIFO and predictor share one block reset
    read_fifo u_read_fifo (
        .pll_afi_clk      (pll_afi_clk),
        .rst_n            (rst_n),
        .blk_rst_n        (blk_rst_n[2]),
        .mem_rdata        (mem_rdata),
        .mem_rdata_strobe (mem_rdata_strobe),
        .rd_pop           (rd_pop),
        .afi_rdata        (afi_rdata),
        .read_underflow   (read_underflow),
        .read_overflow    (read_overflow)
    );

    read_valid_predictor u_rd_valid (
        .pll_afi_clk      (pll_afi_clk),
        .rst_n            (rst_n),
        .blk_rst_n        (blk_rst_n[2]),
        .afi_rdata_en     (afi_rdata_en),
        .phy_read_latency (phy_read_latency),
        .afi_rdata_valid  (afi_rdata_valid),
        .rd_pop           (rd_pop)
    );

endmodule

`default_nettype wire

//--- design/read/read_fifo.sv
////////////////////////////////////////////////////////////
// Read data FIFO
// Buffers captured memory read data until the predicted
// read valid pops it, with sticky overflow and underflow
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module read_fifo
    import phy_cfg_pkg::*;
(
    input  wire            pll_afi_clk,
    input  wire            rst_n,
    input  wire            blk_rst_n,
    input  wire afi_data_t mem_rdata,
    input  wire            mem_rdata_strobe,
    input  wire            rd_pop,
    output afi_data_t      afi_rdata,
    output logic           read_underflow,
    output logic           read_overflow
);

    typedef logic [$clog2(READ_FIFO_DEPTH)-1:0]   fifo_ptr_t;
    typedef logic [$clog2(READ_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

    afi_data_t entry [READ_FIFO_DEPTH];
    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t fill;
    logic      empty;
    logic      full;
    logic      push_ok;
    logic      pop_ok;

    assign empty   = (fill == '0);
    assign full    = (fill == fifo_cnt_t'(READ_FIFO_DEPTH));
    assign push_ok = mem_rdata_strobe && !full;
    assign pop_ok  = rd_pop && !empty;

    // Head entry during a pop, zero otherwise
    assign afi_rdata = pop_ok ? entry[rd_ptr] : '0;

    always_ff @(posedge pll_afi_clk)
    begin
        if (push_ok)
        begin
            entry[wr_ptr] <= mem_rdata;
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge pll_afi_clk or negedge rst_n)
    begin
        if (!rst_n || !blk_rst_n)
        begin
            wr_ptr         <= '0;
            rd_ptr         <= '0;
            fill           <= '0;
            read_underflow <= 1'b0;
            read_overflow  <= 1'b0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
            if (rd_pop && empty)
            begin
                read_underflow <= 1'b1;
            end
            if (mem_rdata_strobe && full)
            begin
                read_overflow <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/read/read_valid_predictor.sv
////////////////////////////////////////////////////////////
// Read valid predictor
// Delays the read request by the programmed latency and
// pops the read FIFO as valid data is returned to the AFI
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module read_valid_predictor
    import phy_cfg_pkg::*;
    import phy_ctrl_pkg::*;
(
    input  wire                       pll_afi_clk,
    input  wire                       rst_n,
    input  wire                       blk_rst_n,
    input  wire [AFI_RATE_RATIO-1:0]  afi_rdata_en,
    input  wire rd_lat_t              phy_read_latency,
    output logic [AFI_RATE_RATIO-1:0] afi_rdata_valid,
    output logic                      rd_pop
);

    logic [MAX_READ_LATENCY-1:0] dly_line;
    logic                        rd_issue;

    // Either rate slot requests one AFI word
    assign rd_issue = |afi_rdata_en;

    always_ff @(posedge pll_afi_clk or negedge rst_n)
    begin
        if (!rst_n || !blk_rst_n)
        begin
            dly_line <= '0;
        end
        else
        begin
            dly_line <= {dly_line[MAX_READ_LATENCY-2:0], rd_issue};
        end
    end

    // Tap n holds a request seen n+1 edges ago
    assign rd_pop = (phy_read_latency != '0) && dly_line[phy_read_latency - 1'b1];

    assign afi_rdata_valid = {AFI_RATE_RATIO{rd_pop}};

endmodule

`default_nettype wire

//--- design/reset/phy_reset_fsm.sv
////////////////////////////////////////////////////////////
// PHY reset sequencer
// Holds controller and datapath blocks in reset until PLL
// lock has been stable for the settle time, and drops all
// resets again on loss of lock or a soft reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module phy_reset_fsm
    import phy_ctrl_pkg::*;
(
    input  wire                      pll_afi_clk,
    input  wire                      rst_n,
    input  wire                      pll_locked,
    input  wire                      soft_reset_n,
    input  wire                      settle_done,
    output logic                     settle_start,
    output logic                     ctl_reset_n,
    output logic [NUM_PHY_RESET-1:0] blk_rst_n
);

    reset_state_t state;
    reset_state_t state_nxt;
    logic         lock_ok;
    logic         release_nxt;

    assign lock_ok = pll_locked && soft_reset_n;

    // Timer loads on the same edge that leaves the wait state
    assign settle_start = (state == RST_WAIT_LOCK) && lock_ok;

    always_comb
    begin
        state_nxt = RST_WAIT_LOCK;
        if (lock_ok)
        begin
            case (state)
                RST_WAIT_LOCK: state_nxt = RST_SETTLE;
                RST_SETTLE:    state_nxt = settle_done ? RST_RUN : RST_SETTLE;
                RST_RUN:       state_nxt = RST_RUN;
                default:       state_nxt = RST_WAIT_LOCK;
            endcase
        end
    end

    // Release one cycle after reaching run, drop on the first bad sample
    assign release_nxt = lock_ok && (state == RST_RUN);

    always_ff @(posedge pll_afi_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= RST_WAIT_LOCK;
            ctl_reset_n <= 1'b0;
            blk_rst_n   <= '0;
        end
        else
        begin
            state       <= state_nxt;
            ctl_reset_n <= release_nxt;
            blk_rst_n   <= {NUM_PHY_RESET{release_nxt}};
        end
    end

endmodule

`default_nettype wire

//--- design/reset/reset_settle_timer.sv
////////////////////////////////////////////////////////////
// Settle timer
// Down-counter loaded at PLL lock, flags when the settle
// interval has elapsed
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module reset_settle_timer
    import phy_ctrl_pkg::*;
(
    input  wire  pll_afi_clk,
    input  wire  rst_n,
    input  wire  settle_start,
    output logic settle_done
);

    settle_cnt_t cnt;

    always_ff @(posedge pll_afi_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt <= '0;
        end
        else if (settle_start)
        begin
            cnt <= settle_cnt_t'(SETTLE_CYCLES);
        end
        else if (cnt != '0)
        begin
            cnt <= cnt - 1'b1;
        end
    end

    // Stays high at zero until the next load
    assign settle_done = (cnt == '0);

endmodule

`default_nettype wire

//--- design/write_path.sv
////////////////////////////////////////////////////////////
// Write path
// Delays write data, mask, write enable and strobe enable
// by a fixed number of AFI cycles
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module write_path
    import phy_cfg_pkg::*;
(
    input  wire            pll_afi_clk,
    input  wire            rst_n,
    input  wire            blk_rst_n,
    input  wire afi_data_t afi_wdata,
    input  wire afi_mask_t afi_dm,
    input  wire afi_dqs_t  afi_wdata_valid,
    input  wire afi_dqs_t  afi_dqs_burst,
    output afi_data_t      mem_wdata,
    output afi_mask_t      mem_dm,
    output afi_dqs_t       mem_wdata_en,
    output afi_dqs_t       mem_dqs_en
);

    afi_data_t wdata_q  [WRITE_FLOP_STAGES];
    afi_mask_t dm_q     [WRITE_FLOP_STAGES];
    afi_dqs_t  wen_q    [WRITE_FLOP_STAGES];
    afi_dqs_t  dqs_en_q [WRITE_FLOP_STAGES];

    // Data and mask, qualified by the enables downstream
    always_ff @(posedge pll_afi_clk)
    begin
        wdata_q[0] <= afi_wdata;
        dm_q[0]    <= afi_dm;
        for (int i = 1; i < WRITE_FLOP_STAGES; i++)
        begin
            wdata_q[i] <= wdata_q[i-1];
            dm_q[i]    <= dm_q[i-1];
        end
    end

    always_ff @(posedge pll_afi_clk or negedge rst_n)
    begin
        if (!rst_n || !blk_rst_n)
        begin
            for (int i = 0; i < WRITE_FLOP_STAGES; i++)
            begin
                wen_q[i]    <= '0;
                dqs_en_q[i] <= '0;
            end
        end
        else
        begin
            wen_q[0]    <= afi_wdata_valid;
            dqs_en_q[0] <= afi_dqs_burst;
            for (int i = 1; i < WRITE_FLOP_STAGES; i++)
            begin
                wen_q[i]    <= wen_q[i-1];
                dqs_en_q[i] <= dqs_en_q[i-1];
            end
        end
    end

    assign mem_wdata    = wdata_q[WRITE_FLOP_STAGES-1];
    assign mem_dm       = dm_q[WRITE_FLOP_STAGES-1];
    assign mem_wdata_en = wen_q[WRITE_FLOP_STAGES-1];
    assign mem_dqs_en   = dqs_en_q[WRITE_FLOP_STAGES-1];

endmodule

`default_nettype wire

//--- project.f
common/phy_cfg_pkg.sv
common/phy_ctrl_pkg.sv
design/reset/reset_settle_timer.sv
design/reset/phy_reset_fsm.sv
design/addr_cmd_path.sv
design/write_path.sv
design/read/read_fifo.sv
design/read/read_valid_predictor.sv
design/ddr_phy_core.sv
tb/tb_ddr_phy_core.sv

//--- tb/tb_ddr_phy_core.sv
////////////////////////////////////////////////////////////
// DDR3 PHY core testbench
// Drives the AFI side from a stimulus table, acts as the
// memory returning read data, and checks command, write
// and read timing against delayed copies of the stimulus
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_ddr_phy_core
    import phy_cfg_pkg::*;
    import phy_ctrl_pkg::*;
();

    localparam int RELEASE_DELAY = SETTLE_CYCLES + 2;
    localparam int LOCK_TIMEOUT  = 64;

    typedef struct packed {
        mem_addr_t                 addr;
        mem_bank_t                 ba;
        logic [3:0]                cmd_n;
        logic                      cke;
        logic                      odt;
        afi_data_t                 wdata;
        afi_mask_t                 dm;
        afi_dqs_t                  wvalid;
        afi_dqs_t                  dqs_burst;
        logic [AFI_RATE_RATIO-1:0] rd_en;
        rd_lat_t                   lat;
        logic                      push;
    } stim_t;

    logic                      pll_afi_clk = 1'b0;
    logic                      rst_n;
    logic                      pll_locked;
    logic                      soft_reset_n;
    logic                      ctl_reset_n;
    mem_addr_t                 afi_addr;
    mem_bank_t                 afi_ba;
    logic                      afi_cs_n;
    logic                      afi_ras_n;
    logic                      afi_cas_n;
    logic                      afi_we_n;
    logic                      afi_cke;
    logic                      afi_odt;
    afi_data_t                 afi_wdata;
    afi_mask_t                 afi_dm;
    afi_dqs_t                  afi_wdata_valid;
    afi_dqs_t                  afi_dqs_burst;
    logic [AFI_RATE_RATIO-1:0] afi_rdata_en;
    rd_lat_t                   phy_read_latency;
    afi_data_t                 afi_rdata;
    logic [AFI_RATE_RATIO-1:0] afi_rdata_valid;
    logic                      read_underflow;
    logic                      read_overflow;
    mem_addr_t                 mem_a;
    mem_bank_t                 mem_ba;
    logic                      mem_cs_n;
    logic                      mem_ras_n;
    logic                      mem_cas_n;
    logic                      mem_we_n;
    logic                      mem_cke;
    logic                      mem_odt;
    afi_data_t                 mem_wdata;
    afi_mask_t                 mem_dm;
    afi_dqs_t                  mem_wdata_en;
    afi_dqs_t                  mem_dqs_en;
    afi_data_t                 mem_rdata;
    logic                      mem_rdata_strobe;

    stim_t       stim_tbl[$];
    stim_t       cmd_hist[$];
    stim_t       wr_hist[$];
    afi_data_t   rd_model[$];
    bit          valid_due [256];
    logic        exp_underflow;

    ddr_phy_core dut0 (.*);

    always #4 pll_afi_clk = ~pll_afi_clk;

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected)
        begin
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    // Deselect with CKE low and all write enables off
    function automatic stim_t idle_stim();
        stim_t s;
        s       = '0;
        s.cmd_n = 4'hf;
        s.lat   = rd_lat_t'(3);
        return s;
    endfunction

    task automatic add_entry(input logic [AFI_RATE_RATIO-1:0] rd_en, input int lat,
                             input logic push);
        stim_t s;
        s.addr      = mem_addr_t'($urandom);
        s.ba        = mem_bank_t'($urandom);
        s.cmd_n     = 4'($urandom);
        s.cke       = 1'b1;
        s.odt       = 1'($urandom);
        s.wdata     = {$urandom, $urandom};
        s.dm        = afi_mask_t'($urandom);
        s.wvalid    = afi_dqs_t'($urandom);
        s.dqs_burst = afi_dqs_t'($urandom);
        s.rd_en     = rd_en;
        s.lat       = rd_lat_t'(lat);
        s.push      = push;
        stim_tbl.push_back(s);
    endtask

    // Long enough for any request to leave the delay line
    task automatic add_idle(input int lat, input int count);
        for (int k = 0; k < count; k++)
        begin
            add_entry('0, lat, 1'b0);
        end
    endtask

    // Back-to-back reads that the memory answers one cycle later
    task automatic add_read_group(input int lat, input int reads);
        for (int k = 0; k <= reads; k++)
        begin
            add_entry((k < reads) ? 2'(k % 3 + 1) : 2'b00, lat, k > 0);
        end
        add_idle(lat, 16);
    endtask

    task automatic drive_entry(input stim_t s);
        afi_addr         = s.addr;
        afi_ba           = s.ba;
        {afi_cs_n, afi_ras_n, afi_cas_n, afi_we_n} = s.cmd_n;
        afi_cke          = s.cke;
        afi_odt          = s.odt;
        afi_wdata        = s.wdata;
        afi_dm           = s.dm;
        afi_wdata_valid  = s.wvalid;
        afi_dqs_burst    = s.dqs_burst;
        afi_rdata_en     = s.rd_en;
        phy_read_latency = s.lat;
        mem_rdata_strobe = s.push;
        if (s.push)
        begin
            mem_rdata = {$urandom, $urandom};
            rd_model.push_back(mem_rdata);
        end
    endtask

    task automatic check_command(input stim_t e);
        check_value("mem_a", mem_a, e.addr);
        check_value("mem_ba", mem_ba, e.ba);
        check_value("mem_cs_n", mem_cs_n, e.cmd_n[3]);
        check_value("mem_ras_n", mem_ras_n, e.cmd_n[2]);
        check_value("mem_cas_n", mem_cas_n, e.cmd_n[1]);
        check_value("mem_we_n", mem_we_n, e.cmd_n[0]);
        check_value("mem_cke", mem_cke, e.cke);
        check_value("mem_odt", mem_odt, e.odt);
    endtask

    task automatic check_write(input stim_t e);
        check_value("mem_wdata", mem_wdata, e.wdata);
        check_value("mem_dm", mem_dm, e.dm);
        check_value("mem_wdata_en", mem_wdata_en, e.wvalid);
        check_value("mem_dqs_en", mem_dqs_en, e.dqs_burst);
    endtask

    task automatic check_read(input int i);
        afi_data_t exp_data;
        exp_data = '0;
        check_value("afi_rdata_valid", afi_rdata_valid, {AFI_RATE_RATIO{valid_due[i]}});
        check_value("read_underflow", read_underflow, exp_underflow);
        check_value("read_overflow", read_overflow, 1'b0);
        if (valid_due[i])
        begin
            if (rd_model.size() > 0)
            begin
                exp_data = rd_model.pop_front();
            end
            else
            begin
                // Flag shows up one cycle after the empty pop
                exp_underflow = 1'b1;
            end
            check_value("afi_rdata", afi_rdata, exp_data);
        end
    endtask

    initial
    begin
        stim_t e;
        int    lock_cycles;
        bit    released;

        void'($urandom(40));
        rst_n        = 1'b0;
        pll_locked   = 1'b0;
        soft_reset_n = 1'b1;
        mem_rdata    = '0;
        drive_entry(idle_stim());

        add_read_group(3, 4);
        add_read_group(7, 5);
        add_read_group(15, 6);
        // Read that the memory never answers
        add_entry(2'b01, 15, 1'b0);
        add_idle(15, 16);

        repeat (10) @(posedge pll_afi_clk);
        #1;
        rst_n = 1'b1;
        @(posedge pll_afi_clk);
        #1;
        check_value("ctl_reset_n", ctl_reset_n, 1'b0);
        check_value("afi_rdata_valid", afi_rdata_valid, 2'b00);
        check_value("read_underflow", read_underflow, 1'b0);
        check_value("mem_wdata_en", mem_wdata_en, 4'h0);
        check_command(idle_stim());

        // Chip select and CKE asserted but held off the pins until release
        e       = idle_stim();
        e.cmd_n = 4'b0111;
        e.cke   = 1'b1;
        drive_entry(e);
        pll_locked  = 1'b1;
        lock_cycles = 0;
        released    = 1'b0;
        while (!released && lock_cycles < LOCK_TIMEOUT)
        begin
            @(posedge pll_afi_clk);
            #1;
            lock_cycles++;
            if (ctl_reset_n === 1'b1)
            begin
                released = 1'b1;
            end
            else
            begin
                check_command(idle_stim());
            end
        end
        if (!released)
        begin
            $display("Timeout: ctl_reset_n was not released after PLL lock");
            stop_run();
        end
        check_value("ctl_reset_n release delay", lock_cycles - 1, RELEASE_DELAY);

        // Command stages hold NOP and then the pre-release command
        cmd_hist.push_back(idle_stim());
        cmd_hist.push_back(e);
        for (int k = 0; k < WRITE_FLOP_STAGES; k++)
        begin
            wr_hist.push_back(idle_stim());
        end
        exp_underflow = 1'b0;

        for (int i = 0; i < stim_tbl.size(); i++)
        begin
            @(posedge pll_afi_clk);
            #1;
            check_value("ctl_reset_n", ctl_reset_n, 1'b1);
            check_command(cmd_hist.pop_front());
            check_write(wr_hist.pop_front());
            check_read(i);
            drive_entry(stim_tbl[i]);
            cmd_hist.push_back(stim_tbl[i]);
            wr_hist.push_back(stim_tbl[i]);
            if (stim_tbl[i].rd_en != '0)
            begin
                valid_due[i + stim_tbl[i].lat] = 1'b1;
            end
        end

        // Lose lock while an active command is presented
        check_value("read_underflow", read_underflow, 1'b1);
        e       = idle_stim();
        e.cmd_n = 4'b0001;
        e.cke   = 1'b1;
        e.addr  = 14'h1abc;
        drive_entry(e);
        pll_locked = 1'b0;
        @(posedge pll_afi_clk);
        #1;
        check_value("ctl_reset_n", ctl_reset_n, 1'b0);
        @(posedge pll_afi_clk);
        #1;
        check_command(idle_stim());
        check_value("read_underflow", read_underflow, 1'b0);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
